// ==== design/processor_pkg.sv ====
`default_nettype none

package processor_pkg;

  // Register and data byte
  typedef logic [7:0] data_t;

  // Instruction memory address
  typedef logic [15:0] addr_t;

  // General register number, 0..3 selects A..D
  typedef logic [1:0] reg_idx_t;

  // Codes not listed here execute as NOP
  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_LDI = 4'd1,
    OP_MOV = 4'd2,
    OP_ADD = 4'd3,
    OP_SUB = 4'd4,
    OP_AND = 4'd5,
    OP_OR  = 4'd6,
    OP_XOR = 4'd7,
    OP_HLT = 4'd15
  } opcode_e;

  // One instruction byte as it sits in memory
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t dst;
    reg_idx_t src;
  } instr_t;

  typedef struct packed {
    logic halt;
    logic negative;
    logic carry;
  } flags_t;

  // Stage-2 writeback towards the register file
  typedef struct packed {
    logic     reg_we;
    reg_idx_t dst;
    data_t    value;
    logic     flags_we;
    logic     carry;
    logic     negative;
    logic     halt;
  } wb_t;

  localparam addr_t RESET_PC = 16'h0000;

  // Placed in stage 1 in place of a constant byte
  localparam instr_t NOP_INSTR = '0;

endpackage

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu (
  input  wire processor_pkg::opcode_e op,
  input  wire processor_pkg::data_t   lhs,
  input  wire processor_pkg::data_t   rhs,
  output processor_pkg::data_t        result,
  output logic                        carry,
  output logic                        negative
);

  // Ninth bit holds the carry out
  logic [8:0] sum;

  always_comb begin
    sum    = '0;
    result = '0;
    carry  = 1'b0;
    case (op)
      processor_pkg::OP_ADD: begin
        sum    = {1'b0, lhs} + {1'b0, rhs};
        result = sum[7:0];
        carry  = sum[8];
      end
      // Carry set after the two's complement subtract means no borrow
      processor_pkg::OP_SUB: begin
        sum    = {1'b0, lhs} + {1'b0, ~rhs} + 9'd1;
        result = sum[7:0];
        carry  = sum[8];
      end
      processor_pkg::OP_AND: result = lhs & rhs;
      processor_pkg::OP_OR:  result = lhs | rhs;
      processor_pkg::OP_XOR: result = lhs ^ rhs;
      default: ;
    endcase
  end

  assign negative = result[7];

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file (
  input  wire                         clk,
  input  wire                         reset,
  input  wire processor_pkg::reg_idx_t lhs_sel,
  input  wire processor_pkg::reg_idx_t rhs_sel,
  output processor_pkg::data_t        lhs_value,
  output processor_pkg::data_t        rhs_value,
  input  wire processor_pkg::wb_t      wb,
  output processor_pkg::data_t        a,
  output processor_pkg::data_t        b,
  output processor_pkg::data_t        c,
  output processor_pkg::data_t        d,
  output processor_pkg::flags_t       flags
);

  // A, B, C, D in index order
  processor_pkg::data_t regs [4];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.reg_we) begin
      regs[wb.dst] <= wb.value;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      if (wb.flags_we) begin
        flags.carry    <= wb.carry;
        flags.negative <= wb.negative;
      end
      // Halt only clears on reset
      if (wb.halt) begin
        flags.halt <= 1'b1;
      end
    end
  end

  assign lhs_value = regs[lhs_sel];
  assign rhs_value = regs[rhs_sel];

  assign a = regs[0];
  assign b = regs[1];
  assign c = regs[2];
  assign d = regs[3];

  // Nothing behind HLT in the pipeline may reach the registers
  no_write_after_halt: assert property (
    @(posedge clk) disable iff (reset)
    flags.halt |-> (!wb.reg_we && !wb.flags_we)
  );

endmodule

`default_nettype wire

// ==== design/instr_fetch.sv ====
`default_nettype none

module instr_fetch (
  input  wire                    clk,
  input  wire                    reset,
  input  wire processor_pkg::data_t mem_data,
  input  wire                    const_fetch,
  input  wire                    halt_req,
  output processor_pkg::addr_t   pc,
  output processor_pkg::instr_t  dispatch
);

  typedef enum logic {
    FETCH_RUN,
    FETCH_HALTED
  } fetch_state_e;

  fetch_state_e state;
  logic         advance;

  // PC stops as soon as HLT reaches stage 1, so it rests at HLT address + 1
  assign advance = (state == FETCH_RUN) && !halt_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH_RUN;
    end else if (halt_req) begin
      state <= FETCH_HALTED;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= processor_pkg::RESET_PC;
    end else if (advance) begin
      pc <= pc + 16'd1;
    end
  end

  // The byte after LDI is data, never an instruction
  assign dispatch = (advance && !const_fetch) ? processor_pkg::instr_t'(mem_data)
                                              : processor_pkg::NOP_INSTR;

  // Halted machine keeps its PC until the next reset
  pc_frozen_when_halted: assert property (
    @(posedge clk) disable iff (reset)
    (state == FETCH_HALTED) |=> (pc == $past(pc))
  );

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  wire                       clk,
  input  wire                       reset,
  input  wire processor_pkg::instr_t dispatch,
  input  wire processor_pkg::data_t  mem_data,
  output processor_pkg::reg_idx_t   lhs_sel,
  output processor_pkg::reg_idx_t   rhs_sel,
  input  wire processor_pkg::data_t  lhs_value,
  input  wire processor_pkg::data_t  rhs_value,
  output logic                      const_fetch,
  output logic                      halt_req,
  output processor_pkg::wb_t        wb
);

  processor_pkg::instr_t stage1;
  processor_pkg::data_t  lhs_op;
  processor_pkg::data_t  rhs_op;
  processor_pkg::data_t  alu_result;
  logic                  alu_carry;
  logic                  alu_negative;
  processor_pkg::wb_t    wb_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage1 <= processor_pkg::NOP_INSTR;
    end else begin
      stage1 <= dispatch;
    end
  end

  // LHS is the destination register, RHS the source
  assign lhs_sel = stage1.dst;
  assign rhs_sel = stage1.src;

  // Stage 2 has not written yet, so take its value directly
  assign lhs_op = (wb.reg_we && wb.dst == stage1.dst) ? wb.value : lhs_value;
  assign rhs_op = (wb.reg_we && wb.dst == stage1.src) ? wb.value : rhs_value;

  alu alu0 (
    .op       (stage1.opcode),
    .lhs      (lhs_op),
    .rhs      (rhs_op),
    .result   (alu_result),
    .carry    (alu_carry),
    .negative (alu_negative)
  );

  assign const_fetch = (stage1.opcode == processor_pkg::OP_LDI);
  assign halt_req    = (stage1.opcode == processor_pkg::OP_HLT);

  always_comb begin
    wb_next          = '0;
    wb_next.dst      = stage1.dst;
    wb_next.value    = alu_result;
    wb_next.carry    = alu_carry;
    wb_next.negative = alu_negative;
    case (stage1.opcode)
      // Constant byte is on the memory bus this very cycle
      processor_pkg::OP_LDI: begin
        wb_next.reg_we = 1'b1;
        wb_next.value  = mem_data;
      end
      processor_pkg::OP_MOV: begin
        wb_next.reg_we = 1'b1;
        wb_next.value  = rhs_op;
      end
      processor_pkg::OP_ADD, processor_pkg::OP_SUB, processor_pkg::OP_AND,
      processor_pkg::OP_OR, processor_pkg::OP_XOR: begin
        wb_next.reg_we   = 1'b1;
        wb_next.flags_we = 1'b1;
      end
      processor_pkg::OP_HLT: wb_next.halt = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb <= wb_next;
    end
  end

  // Fetch relies on these two being exclusive
  fetch_requests_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(const_fetch && halt_req)
  );

endmodule

`default_nettype wire

// ==== design/processor.sv ====
`default_nettype none

module processor (
  input  wire                       clk,
  input  wire                       reset,
  input  wire processor_pkg::data_t mem_data,
  output processor_pkg::addr_t      mem_addr,
  output processor_pkg::data_t      a,
  output processor_pkg::data_t      b,
  output processor_pkg::data_t      c,
  output processor_pkg::data_t      d,
  output processor_pkg::flags_t     flags,
  output processor_pkg::addr_t      pc,
  output logic                      halt
);

  processor_pkg::instr_t   dispatch;
  logic                    const_fetch;
  logic                    halt_req;
  processor_pkg::reg_idx_t lhs_sel;
  processor_pkg::reg_idx_t rhs_sel;
  processor_pkg::data_t    lhs_value;
  processor_pkg::data_t    rhs_value;
  processor_pkg::wb_t      wb;

  instr_fetch fetch0 (
    .clk         (clk),
    .reset       (reset),
    .mem_data    (mem_data),
    .const_fetch (const_fetch),
    .halt_req    (halt_req),
    .pc          (pc),
    .dispatch    (dispatch)
  );

  execute_stage exec0 (
    .clk         (clk),
    .reset       (reset),
    .dispatch    (dispatch),
    .mem_data    (mem_data),
    .lhs_sel     (lhs_sel),
    .rhs_sel     (rhs_sel),
    .lhs_value   (lhs_value),
    .rhs_value   (rhs_value),
    .const_fetch (const_fetch),
    .halt_req    (halt_req),
    .wb          (wb)
  );

  reg_file regs0 (
    .clk       (clk),
    .reset     (reset),
    .lhs_sel   (lhs_sel),
    .rhs_sel   (rhs_sel),
    .lhs_value (lhs_value),
    .rhs_value (rhs_value),
    .wb        (wb),
    .a         (a),
    .b         (b),
    .c         (c),
    .d         (d),
    .flags     (flags)
  );

  // Memory is always addressed by the PC
  assign mem_addr = pc;
  assign halt     = flags.halt;

endmodule

`default_nettype wire

// ==== testbench/isa_model.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH
`default_nettype none

// Instruction-level model that runs mem from address 0 until HLT
task automatic run_model();
  processor_pkg::instr_t ins;
  processor_pkg::data_t  lhs;
  processor_pkg::data_t  rhs;
  int                    sum;
  int                    steps;
  exp_regs  = '{default: '0};
  exp_flags = '0;
  exp_pc    = processor_pkg::RESET_PC;
  for (steps = 0; steps < 256 && !exp_flags.halt; steps++) begin
    ins    = processor_pkg::instr_t'(mem[exp_pc[7:0]]);
    exp_pc = exp_pc + 16'd1;
    lhs    = exp_regs[ins.dst];
    rhs    = exp_regs[ins.src];
    sum    = -1;
    case (ins.opcode)
      processor_pkg::OP_LDI: begin
        exp_regs[ins.dst] = mem[exp_pc[7:0]];
        exp_pc = exp_pc + 16'd1;
      end
      processor_pkg::OP_MOV: exp_regs[ins.dst] = rhs;
      processor_pkg::OP_ADD: sum = int'(lhs) + int'(rhs);
      // Offset by 256 so that a sum above 255 means no borrow
      processor_pkg::OP_SUB: sum = int'(lhs) - int'(rhs) + 256;
      processor_pkg::OP_AND: sum = int'(lhs & rhs);
      processor_pkg::OP_OR:  sum = int'(lhs | rhs);
      processor_pkg::OP_XOR: sum = int'(lhs ^ rhs);
      processor_pkg::OP_HLT: exp_flags.halt = 1'b1;
      default: ;
    endcase
    // Only ALU ops leave a sum and touch the flags
    if (sum >= 0) begin
      exp_regs[ins.dst]  = processor_pkg::data_t'(sum);
      exp_flags.carry    = (sum > 255);
      exp_flags.negative = sum[7];
    end
  end
  if (!exp_flags.halt) begin
    $display("Model error at %0t ns: program has no reachable HLT", $time);
    error_count++;
  end
endtask

task automatic check_data(input string name, input processor_pkg::data_t actual,
                          input processor_pkg::data_t expected);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic check_flags(input string name, input processor_pkg::flags_t actual,
                           input processor_pkg::flags_t expected);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic check_addr(input string name, input processor_pkg::addr_t actual,
                          input processor_pkg::addr_t expected);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
    error_count++;
  end
endtask

`default_nettype wire
`endif

// ==== testbench/processor_tb.sv ====
`default_nettype none

module processor_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk;
  logic                  reset;
  processor_pkg::data_t  mem_data;
  processor_pkg::addr_t  mem_addr;
  processor_pkg::data_t  a, b, c, d;
  processor_pkg::flags_t flags;
  processor_pkg::addr_t  pc;
  logic                  halt;

  // Instruction memory and the model's expected final state
  processor_pkg::data_t  mem [256];
  processor_pkg::data_t  exp_regs [4];
  processor_pkg::flags_t exp_flags;
  processor_pkg::addr_t  exp_pc;

  int     prog_len;
  int     error_count;
  int     errors_seen;
  int     tests_run;
  int     tests_failed;
  int     cycle_count;
  int     cycle_limit;
  integer seed;

  processor dut0 (
    .clk      (clk),
    .reset    (reset),
    .mem_data (mem_data),
    .mem_addr (mem_addr),
    .a        (a),
    .b        (b),
    .c        (c),
    .d        (d),
    .flags    (flags),
    .pc       (pc),
    .halt     (halt)
  );

  assign mem_data = mem[mem_addr[7:0]];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Limit grows by each program's budget as it is started
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles: the processor never halted", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic processor_pkg::data_t encode(input logic [3:0] op,
                                                  input processor_pkg::reg_idx_t dst,
                                                  input processor_pkg::reg_idx_t src);
    return {op, dst, src};
  endfunction

  task automatic emit(input processor_pkg::data_t value);
    mem[prog_len] = value;
    prog_len++;
  endtask

  task automatic emit_ldi(input processor_pkg::reg_idx_t dst, input processor_pkg::data_t value);
    emit(encode(processor_pkg::OP_LDI, dst, 2'd0));
    emit(value);
  endtask

  // Memory is rewritten while reset holds the DUT
  task automatic begin_program();
    reset    = 1'b1;
    prog_len = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
  endtask

  task automatic release_reset();
    cycle_limit = cycle_limit + 2 * prog_len + 20;
    repeat (5) @(posedge clk);
    #10 reset = 1'b0;
  endtask

  task automatic check_regs(input processor_pkg::data_t ea, input processor_pkg::data_t eb,
                            input processor_pkg::data_t ec, input processor_pkg::data_t ed);
    check_data("a", a, ea);
    check_data("b", b, eb);
    check_data("c", c, ec);
    check_data("d", d, ed);
  endtask

  task automatic run_program();
    run_model();
    release_reset();
    while (!halt) begin
      @(posedge clk);
      #10;
    end
    check_regs(exp_regs[0], exp_regs[1], exp_regs[2], exp_regs[3]);
    check_flags("flags", flags, exp_flags);
    check_addr("pc", pc, exp_pc);
    check_addr("mem_addr", mem_addr, exp_pc);
  endtask

  task automatic run_alu_case(input logic [3:0] op, input processor_pkg::data_t lhs,
                              input processor_pkg::data_t rhs);
    begin_program();
    emit_ldi(2'd0, lhs);
    emit_ldi(2'd1, rhs);
    emit(encode(op, 2'd0, 2'd1));
    emit(encode(processor_pkg::OP_HLT, 2'd0, 2'd0));
    run_program();
  endtask

  task automatic finish_test(input string name);
    int errors;
    errors      = error_count - errors_seen;
    errors_seen = error_count;
    tests_run++;
    if (errors == 0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d check errors", name, errors);
    end
  endtask

  initial begin
    logic [3:0] op;
    int         h;
    reset        = 1'b1;
    seed         = 41;
    error_count  = 0;
    errors_seen  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;
    cycle_limit  = 0;

    // First edge out of reset moves the PC to 1
    begin_program();
    release_reset();
    @(posedge clk);
    #10;
    check_regs(8'h00, 8'h00, 8'h00, 8'h00);
    check_flags("flags", flags, '0);
    check_bit("halt", halt, 1'b0);
    check_addr("pc", pc, 16'd1);
    finish_test("reset");

    // Constants look like HLT, MOV and LDI if ever executed
    begin_program();
    emit_ldi(2'd0, 8'h12);
    emit_ldi(2'd1, 8'hF0);
    emit_ldi(2'd2, 8'h2C);
    emit_ldi(2'd3, 8'h13);
    emit(encode(processor_pkg::OP_MOV, 2'd0, 2'd2));
    emit(encode(processor_pkg::OP_MOV, 2'd3, 2'd1));
    emit(encode(processor_pkg::OP_HLT, 2'd0, 2'd0));
    run_program();
    finish_test("constants");

    run_alu_case(processor_pkg::OP_ADD, 8'hF0, 8'h20);
    run_alu_case(processor_pkg::OP_ADD, 8'h7F, 8'h01);
    run_alu_case(processor_pkg::OP_SUB, 8'h05, 8'h07);
    run_alu_case(processor_pkg::OP_SUB, 8'h80, 8'h01);
    run_alu_case(processor_pkg::OP_AND, 8'hF0, 8'h3C);
    run_alu_case(processor_pkg::OP_OR, 8'h81, 8'h02);
    run_alu_case(processor_pkg::OP_XOR, 8'hFF, 8'h0F);
    finish_test("alu");

    // Every op reads the result of the one right before it
    begin_program();
    emit_ldi(2'd0, 8'h01);
    emit(encode(processor_pkg::OP_ADD, 2'd0, 2'd0));
    emit(encode(processor_pkg::OP_ADD, 2'd0, 2'd0));
    emit(encode(processor_pkg::OP_MOV, 2'd1, 2'd0));
    emit(encode(processor_pkg::OP_ADD, 2'd1, 2'd0));
    emit(encode(processor_pkg::OP_SUB, 2'd0, 2'd1));
    emit(encode(processor_pkg::OP_XOR, 2'd2, 2'd0));
    emit(encode(processor_pkg::OP_MOV, 2'd3, 2'd2));
    emit(encode(processor_pkg::OP_OR, 2'd3, 2'd1));
    emit(encode(processor_pkg::OP_AND, 2'd0, 2'd3));
    emit(encode(processor_pkg::OP_HLT, 2'd0, 2'd0));
    run_program();
    finish_test("bypass");

    begin_program();
    emit_ldi(2'd1, 8'h5A);
    emit(encode(processor_pkg::OP_ADD, 2'd1, 2'd1));
    h = prog_len;
    emit(encode(processor_pkg::OP_HLT, 2'd0, 2'd0));
    emit_ldi(2'd1, 8'h77);
    emit(encode(processor_pkg::OP_MOV, 2'd0, 2'd1));
    emit(encode(processor_pkg::OP_ADD, 2'd2, 2'd1));
    run_program();
    check_addr("pc", pc, processor_pkg::addr_t'(h + 1));
    repeat (10) begin
      @(posedge clk);
      #10;
      check_regs(exp_regs[0], exp_regs[1], exp_regs[2], exp_regs[3]);
      check_addr("pc", pc, processor_pkg::addr_t'(h + 1));
      check_bit("halt", halt, 1'b1);
    end
    finish_test("halt");

    // Unused opcodes 8 to 14 are drawn too and run as NOP
    for (int p = 0; p < 20; p++) begin
      begin_program();
      for (int i = 0; i < 30; i++) begin
        op = 4'({$random(seed)} % 32'd15);
        emit(encode(op, processor_pkg::reg_idx_t'($random(seed)),
                    processor_pkg::reg_idx_t'($random(seed))));
        if (op == processor_pkg::OP_LDI) begin
          emit(processor_pkg::data_t'($random(seed)));
        end
      end
      emit(encode(processor_pkg::OP_HLT, 2'd0, 2'd0));
      run_program();
      finish_test($sformatf("random %0d", p));
    end

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  `include "isa_model.svh"

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+testbench
design/processor_pkg.sv
design/alu.sv
design/reg_file.sv
design/instr_fetch.sv
design/execute_stage.sv
design/processor.sv
testbench/processor_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= processor_tb
RTL_TOP    ?= processor
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

# Lints the RTL below the processor top level
lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) -f $(FILELIST)

# Builds and runs the testbench, the status comes from the pass message search
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
